//--- frv_pkg.sv
/*
 * Shared widths, the MMIO map, the trap cause codes and the FSM encodings
 * of the uncore. The MMIO region is a single 4 KiB page holding four
 * 32-bit words. Interrupt cause codes follow the machine-mode mcause
 * numbering; the NMI code is implementation specific.
 */
package frv_pkg;

  // --------------------------------------------------
  // Widths

  typedef logic [31:0] xword_t;    // MMIO data / address word
  typedef logic [63:0] ctr_t;      // Machine counter value
  typedef logic [ 5:0] cause_t;    // Trap cause to write-back
  typedef logic [ 3:0] ex_cause_t; // External interrupt cause code

  // --------------------------------------------------
  // MMIO map

  localparam xword_t MMIO_BASE_ADDR   = 32'h0000_1000; // Region base
  localparam xword_t MMIO_BASE_MASK   = 32'hFFFF_F000; // Region select bits
  localparam xword_t MMIO_OFFSET_MASK = ~MMIO_BASE_MASK; // Offset bits in region

  localparam xword_t MMIO_MTIME_LO    = 32'h0000_0000; // mtime[31:0]
  localparam xword_t MMIO_MTIME_HI    = 32'h0000_0004; // mtime[63:32]
  localparam xword_t MMIO_MTIMECMP_LO = 32'h0000_0008; // mtimecmp[31:0]
  localparam xword_t MMIO_MTIMECMP_HI = 32'h0000_000C; // mtimecmp[63:32]

  // --------------------------------------------------
  // Trap causes

  localparam cause_t CAUSE_NMI      = 6'd63; // Non-maskable interrupt
  localparam cause_t CAUSE_MSI      = 6'd3;  // Machine software interrupt
  localparam cause_t CAUSE_MTI      = 6'd7;  // Machine timer interrupt
  localparam cause_t CAUSE_MEI_BASE = 6'd16; // Plus ex_cause for externals

  // Compare value out of reset, so no timer interrupt fires early
  localparam ctr_t MTIMECMP_RESET = '1;

  // --------------------------------------------------
  // FSM encodings

  // Four-phase MMIO slave in frv_counters
  typedef enum logic [1:0] {
    MMIO_IDLE,      // Waiting for req
    MMIO_ACK,       // Access performed, ack raised
    MMIO_WAIT_DROP  // Holding ack until req falls
  } mmio_state_t;

  // Trap request to write-back in frv_interrupt
  typedef enum logic [1:0] {
    TRAP_IDLE,         // Arbitrating pending sources
    TRAP_REQ,          // Request up, cause frozen
    TRAP_WAIT_ACK_LOW  // Request dropped, waiting for ack to fall
  } trap_state_t;

endpackage

//--- frv_counters.sv
`timescale 1ns/1ps
/*
 * Machine cycle / instret / mtime counters, mtimecmp and their MMIO slave.
 * Only whole 32-bit word accesses are decoded; there are no byte strobes.
 * One four-phase transfer at a time. Bad addresses return error and zero.
 * A written mtime word skips the increment on the edge of the write.
 */
module frv_counters import frv_pkg::*; (
  input  logic   g_clk,       // Global clock
  input  logic   reset,       // Synchronous, active high
  input  logic   instr_ret,   // Instruction retired
  input  logic   inhibit_cy,  // Stop cycle counting
  input  logic   inhibit_tm,  // Stop mtime counting
  input  logic   inhibit_ir,  // Stop instret counting
  input  logic   mmio_req,    // Four-phase request
  input  logic   mmio_wen,    // Write when set
  input  xword_t mmio_addr,   // Byte address
  input  xword_t mmio_wdata,  // Write data
  output logic   mmio_ack,    // Four-phase acknowledge
  output logic   mmio_error,  // Address not decoded
  output xword_t mmio_rdata,  // Read data, valid with ack
  output logic   ti_pending,  // mtime >= mtimecmp, registered
  output ctr_t   ctr_cycle,   // cycle counter
  output ctr_t   ctr_instret, // instret counter
  output ctr_t   ctr_time     // mtime
);

  // --------------------------------------------------
  // Address decode

  ctr_t        mtimecmp;     // Timer compare value
  mmio_state_t mmio_state;   // Slave FSM
  xword_t      offset;       // Offset inside region
  logic        in_region;    // Address hits the MMIO page
  logic        sel_time_lo;
  logic        sel_time_hi;
  logic        sel_cmp_lo;
  logic        sel_cmp_hi;
  logic        addr_ok;      // One of the four words
  xword_t      read_word;    // Selected register, zero when unmapped
  logic        do_write;     // Write strobe on the access edge

  always_comb begin
    in_region   = (mmio_addr & MMIO_BASE_MASK) == MMIO_BASE_ADDR;
    offset      = mmio_addr & MMIO_OFFSET_MASK;
    sel_time_lo = in_region && (offset == MMIO_MTIME_LO);
    sel_time_hi = in_region && (offset == MMIO_MTIME_HI);
    sel_cmp_lo  = in_region && (offset == MMIO_MTIMECMP_LO);
    sel_cmp_hi  = in_region && (offset == MMIO_MTIMECMP_HI);
    addr_ok     = sel_time_lo | sel_time_hi | sel_cmp_lo | sel_cmp_hi;
    // Write lands only in the ACK phase, so held req has no side effect
    do_write    = (mmio_state == MMIO_ACK) && mmio_wen;

    read_word = '0; // Error reads give zero
    if (sel_time_lo) begin
      read_word = ctr_time[31:0];
    end else if (sel_time_hi) begin
      read_word = ctr_time[63:32];
    end else if (sel_cmp_lo) begin
      read_word = mtimecmp[31:0];
    end else if (sel_cmp_hi) begin
      read_word = mtimecmp[63:32];
    end
  end

  // --------------------------------------------------
  // Four-phase MMIO slave

  always_ff @(posedge g_clk) begin
    if (reset) begin
      mmio_state <= MMIO_IDLE;
      mmio_ack   <= 1'b0;
      mmio_error <= 1'b0;
    end else begin
      unique case (mmio_state)
        MMIO_IDLE: begin
          if (mmio_req) begin
            mmio_state <= MMIO_ACK; // Req sampled, access next edge
          end
        end
        MMIO_ACK: begin
          mmio_ack   <= 1'b1;
          mmio_error <= !addr_ok;
          mmio_state <= MMIO_WAIT_DROP;
        end
        MMIO_WAIT_DROP: begin
          if (!mmio_req) begin
            mmio_ack   <= 1'b0; // Master let go
            mmio_state <= MMIO_IDLE;
          end
        end
        default: begin
          mmio_state <= MMIO_IDLE;
        end
      endcase
    end
  end

  // Read data captured on the ack edge
  always_ff @(posedge g_clk) begin
    if (mmio_state == MMIO_ACK) begin
      mmio_rdata <= read_word;
    end
  end

  // --------------------------------------------------
  // Counters

  always_ff @(posedge g_clk) begin
    if (reset) begin
      ctr_cycle <= '0;
    end else if (!inhibit_cy) begin
      ctr_cycle <= ctr_cycle + ctr_t'(1);
    end
  end

  always_ff @(posedge g_clk) begin
    if (reset) begin
      ctr_instret <= '0;
    end else if (instr_ret && !inhibit_ir) begin
      ctr_instret <= ctr_instret + ctr_t'(1); // One per retire
    end
  end

  // MMIO write wins over the increment on that edge
  always_ff @(posedge g_clk) begin
    if (reset) begin
      ctr_time <= '0;
    end else if (do_write && sel_time_lo) begin
      ctr_time[31:0] <= mmio_wdata;
    end else if (do_write && sel_time_hi) begin
      ctr_time[63:32] <= mmio_wdata;
    end else if (!inhibit_tm) begin
      ctr_time <= ctr_time + ctr_t'(1);
    end
  end

  always_ff @(posedge g_clk) begin
    if (reset) begin
      mtimecmp <= MTIMECMP_RESET;
    end else if (do_write && sel_cmp_lo) begin
      mtimecmp[31:0] <= mmio_wdata;
    end else if (do_write && sel_cmp_hi) begin
      mtimecmp[63:32] <= mmio_wdata;
    end
  end

  // --------------------------------------------------
  // Timer compare

  always_ff @(posedge g_clk) begin
    if (reset) begin
      ti_pending <= 1'b0;
    end else begin
      ti_pending <= (ctr_time >= mtimecmp); // Follows a cmp write by one cycle
    end
  end

endmodule

//--- frv_interrupt.sv
`timescale 1ns/1ps
/*
 * Interrupt pending registers and trap request to write-back.
 * Sources are level sensitive; a source still high after the trap
 * handshake raises a new request. Priority is NMI, external, software,
 * timer. The cause is frozen while int_trap_req is high.
 */
module frv_interrupt import frv_pkg::*; (
  input  logic      g_clk,          // Global clock
  input  logic      reset,          // Synchronous, active high
  input  logic      mstatus_mie,    // Global interrupt enable
  input  logic      mie_meie,       // External enable
  input  logic      mie_mtie,       // Timer enable
  input  logic      mie_msie,       // Software enable
  input  logic      nmi_pending,    // Non-maskable source
  input  logic      ex_pending,     // External source
  input  ex_cause_t ex_cause,       // External cause code
  input  logic      ti_pending,     // Timer source from frv_counters
  input  logic      sw_pending,     // Software source
  output logic      mip_meip,       // External pending
  output logic      mip_mtip,       // Timer pending
  output logic      mip_msip,       // Software pending
  output logic      int_trap_req,   // Trap request to write-back
  output cause_t    int_trap_cause, // Cause, valid with req
  input  logic      int_trap_ack    // Write-back has taken the trap
);

  logic        nmi_q;        // Registered NMI line
  ex_cause_t   ex_cause_q;   // Cause aligned with mip_meip
  logic        take_nmi;
  logic        take_ext;
  logic        take_sw;
  logic        take_ti;
  logic        any_take;     // Some source may trap
  cause_t      sel_cause;    // Winner of arbitration
  trap_state_t trap_state;

  // --------------------------------------------------
  // Pending registers

  always_ff @(posedge g_clk) begin
    if (reset) begin
      nmi_q    <= 1'b0;
      mip_meip <= 1'b0;
      mip_mtip <= 1'b0;
      mip_msip <= 1'b0;
    end else begin
      nmi_q    <= nmi_pending;
      mip_meip <= ex_pending;
      mip_mtip <= ti_pending;
      mip_msip <= sw_pending; // One cycle behind the source
    end
  end

  always_ff @(posedge g_clk) begin
    ex_cause_q <= ex_cause;
  end

  // --------------------------------------------------
  // Priority select

  always_comb begin
    take_nmi = nmi_q; // Ignores all enables
    take_ext = mstatus_mie && mie_meie && mip_meip;
    take_sw  = mstatus_mie && mie_msie && mip_msip;
    take_ti  = mstatus_mie && mie_mtie && mip_mtip;
    any_take = take_nmi | take_ext | take_sw | take_ti;

    if (take_nmi) begin
      sel_cause = CAUSE_NMI;
    end else if (take_ext) begin
      sel_cause = CAUSE_MEI_BASE + {2'b00, ex_cause_q};
    end else if (take_sw) begin
      sel_cause = CAUSE_MSI;
    end else begin
      sel_cause = CAUSE_MTI; // Also the don't-care when nothing pends
    end
  end

  // --------------------------------------------------
  // Trap request handshake

  always_ff @(posedge g_clk) begin
    if (reset) begin
      trap_state   <= TRAP_IDLE;
      int_trap_req <= 1'b0;
    end else begin
      unique case (trap_state)
        TRAP_IDLE: begin
          if (any_take) begin
            int_trap_req <= 1'b1;
            trap_state   <= TRAP_REQ;
          end
        end
        TRAP_REQ: begin
          if (int_trap_ack) begin
            int_trap_req <= 1'b0; // Drop one cycle after ack
            trap_state   <= TRAP_WAIT_ACK_LOW;
          end
        end
        TRAP_WAIT_ACK_LOW: begin
          if (!int_trap_ack) begin
            trap_state <= TRAP_IDLE; // Rearbitrate next edge
          end
        end
        default: begin
          trap_state <= TRAP_IDLE;
        end
      endcase
    end
  end

  // Cause captured with the rising req, frozen until idle again
  always_ff @(posedge g_clk) begin
    if ((trap_state == TRAP_IDLE) && any_take) begin
      int_trap_cause <= sel_cause;
    end
  end

endmodule

//--- frv_uncore.sv
`timescale 1ns/1ps
/*
 * Uncore of the core: counters with the MMIO timer beside the
 * interrupt unit. The pipeline side drives retire, enables and acks.
 * int_mtime is the registered timer pending bit.
 */
module frv_uncore import frv_pkg::*; (
  input  logic      g_clk,            // Global clock
  input  logic      reset,            // Synchronous, active high
  input  logic      instr_ret,        // Instruction retired
  input  logic      inhibit_cy,       // Stop cycle counting
  input  logic      inhibit_tm,       // Stop mtime counting
  input  logic      inhibit_ir,       // Stop instret counting
  input  logic      mstatus_mie,      // Global interrupt enable
  input  logic      mie_meie,         // External enable
  input  logic      mie_mtie,         // Timer enable
  input  logic      mie_msie,         // Software enable
  input  logic      int_nmi,          // Non-maskable interrupt
  input  logic      int_external,     // External interrupt line
  input  ex_cause_t int_extern_cause, // External cause code
  input  logic      int_software,     // Software interrupt line
  input  logic      int_trap_ack,     // Write-back took the trap
  input  logic      mmio_req,         // MMIO request
  input  logic      mmio_wen,         // MMIO write enable
  input  xword_t    mmio_addr,        // MMIO address
  input  xword_t    mmio_wdata,       // MMIO write data
  output logic      mmio_ack,         // MMIO acknowledge
  output logic      mmio_error,       // MMIO decode error
  output xword_t    mmio_rdata,       // MMIO read data
  output logic      int_mtime,        // Timer interrupt pending
  output logic      int_trap_req,     // Trap request to write-back
  output cause_t    int_trap_cause,   // Trap cause
  output logic      mip_meip,         // External pending
  output logic      mip_mtip,         // Timer pending
  output logic      mip_msip,         // Software pending
  output ctr_t      ctr_cycle,        // cycle counter
  output ctr_t      ctr_instret,      // instret counter
  output ctr_t      ctr_time          // mtime
);

  logic ti_pending; // Counters to interrupt unit

  assign int_mtime = mip_mtip;

  // --------------------------------------------------
  // Counters and timer

  frv_counters i_counters (
    .g_clk       (g_clk),
    .reset       (reset),
    .instr_ret   (instr_ret),
    .inhibit_cy  (inhibit_cy),
    .inhibit_tm  (inhibit_tm),
    .inhibit_ir  (inhibit_ir),
    .mmio_req    (mmio_req),
    .mmio_wen    (mmio_wen),
    .mmio_addr   (mmio_addr),
    .mmio_wdata  (mmio_wdata),
    .mmio_ack    (mmio_ack),
    .mmio_error  (mmio_error),
    .mmio_rdata  (mmio_rdata),
    .ti_pending  (ti_pending),
    .ctr_cycle   (ctr_cycle),
    .ctr_instret (ctr_instret),
    .ctr_time    (ctr_time)
  );

  // --------------------------------------------------
  // Interrupt unit

  frv_interrupt i_interrupts (
    .g_clk          (g_clk),
    .reset          (reset),
    .mstatus_mie    (mstatus_mie),
    .mie_meie       (mie_meie),
    .mie_mtie       (mie_mtie),
    .mie_msie       (mie_msie),
    .nmi_pending    (int_nmi),
    .ex_pending     (int_external),
    .ex_cause       (int_extern_cause),
    .ti_pending     (ti_pending),   // Registered compare
    .sw_pending     (int_software),
    .mip_meip       (mip_meip),
    .mip_mtip       (mip_mtip),
    .mip_msip       (mip_msip),
    .int_trap_req   (int_trap_req),
    .int_trap_cause (int_trap_cause),
    .int_trap_ack   (int_trap_ack)
  );

endmodule

//--- frv_uncore_checker.sv
`timescale 1ns/1ps
/*
 * Checker beside the DUT. Value compares come in through compare(),
 * and the trap port is watched for a cause that moves under a held req.
 * Monitors sample on the falling edge, away from DUT updates.
 */
module frv_uncore_checker import frv_pkg::*; (
  input  logic        g_clk,
  input  logic        reset,
  input  logic        mmio_ack,
  input  logic        int_trap_req,
  input  cause_t      int_trap_cause,
  output int unsigned error_count // Mismatches seen so far
);

  logic   req_q;   // Request at the previous sample
  cause_t cause_q; // Cause at the previous sample
  logic   reset_q;

  initial begin
    error_count = 0;
    req_q       = 1'b0;
    cause_q     = '0;
    reset_q     = 1'b1;
  end

  // --------------------------------------------------
  // Value compare

  task automatic compare(input logic [8*24-1:0] test, input logic [63:0] expected,
                         input logic [63:0] actual);
    if (expected !== actual) begin
      $display("mismatch %0s expected %0h actual %0h", test, expected, actual);
      error_count++;
    end
  endtask

  // --------------------------------------------------
  // Port monitors

  always @(negedge g_clk) begin
    if (reset_q && !reset && (mmio_ack || int_trap_req)) begin
      $display("handshake outputs were not low when reset ended"); // Out of reset
      error_count++;
    end
    if (!reset && req_q && int_trap_req && (int_trap_cause != cause_q)) begin
      $display("mismatch trap_frozen expected %0h actual %0h", cause_q, int_trap_cause);
      error_count++;
    end
    reset_q = reset;
    req_q   = int_trap_req;
    cause_q = int_trap_cause;
  end

endmodule

//--- tb_frv_uncore.sv
`timescale 1ns/1ps
/*
 * Testbench for the uncore. It acts as the pipeline side: MMIO master,
 * retire pulses, enables, interrupt sources and the trap acknowledge.
 * Records come from frv_uncore_stim.txt, which is read from the project root.
 * Every handshake wait gives up after 50 cycles.
 */
module tb_frv_uncore import frv_pkg::*; ();

  logic      g_clk;
  logic      reset;
  logic      instr_ret, inhibit_cy, inhibit_tm, inhibit_ir;
  logic      mstatus_mie, mie_meie, mie_mtie, mie_msie;
  logic      int_nmi, int_external, int_software, int_trap_ack;
  ex_cause_t int_extern_cause;
  logic      mmio_req, mmio_wen, mmio_ack, mmio_error;
  xword_t    mmio_addr, mmio_wdata, mmio_rdata;
  logic      int_mtime, int_trap_req, mip_meip, mip_mtip, mip_msip;
  cause_t    int_trap_cause;
  ctr_t      ctr_cycle, ctr_instret, ctr_time;

  int unsigned          mismatches;      // Counted by the checker
  int unsigned          other_failures;  // Timeouts, file problems
  logic                 stop;            // Abort after a timeout
  logic [8*128-1:0]     line;
  logic [8*24-1:0]      name, op;        // Test name and operation
  logic [63:0]          arg_a, arg_b, exp_v;
  xword_t               last_rd;         // mtime low word from snap
  ctr_t                 time_edges;      // Edges since reset, records never write mtime
  int                   fd, r;

  // --------------------------------------------------
  // Clock, DUT and checker

  initial g_clk = 1'b0;
  always #2 g_clk = ~g_clk; // 4 ns period

  // Expected mtime, one count per edge out of reset
  always @(posedge g_clk) begin
    if (reset) begin
      time_edges <= '0;
    end else begin
      time_edges <= time_edges + 64'd1;
    end
  end

  frv_uncore i_frv_uncore (.*);

  frv_uncore_checker i_checker (
    .g_clk          (g_clk),
    .reset          (reset),
    .mmio_ack       (mmio_ack),
    .int_trap_req   (int_trap_req),
    .int_trap_cause (int_trap_cause),
    .error_count    (mismatches)
  );

  // --------------------------------------------------
  // Pipeline-side tasks, all entered 1 ns after an edge

  task automatic report_timeout(input string what);
    $display("timeout: %s", what);
    other_failures++;
    stop = 1'b1; // End the run after this record
  endtask

  task automatic next_cycle();
    @(posedge g_clk);
    #1;
  endtask

  task automatic mmio_access(input logic wen, input xword_t addr, input xword_t wdata,
                             output xword_t rdata, output logic err);
    int n;
    rdata      = '0;
    err        = 1'b1;
    mmio_req   = 1'b1; // Phase 1
    mmio_wen   = wen;
    mmio_addr  = addr;
    mmio_wdata = wdata;
    n = 0;
    while (!mmio_ack && n < 50) begin
      next_cycle();
      n++;
    end
    if (!mmio_ack) begin
      report_timeout("slave never raised mmio_ack");
    end else begin
      rdata = mmio_rdata; // Valid with ack
      err   = mmio_error;
    end
    mmio_req = 1'b0; // Phase 3
    n = 0;
    while (mmio_ack && n < 50) begin
      next_cycle();
      n++;
    end
    if (mmio_ack) begin
      report_timeout("slave held mmio_ack after req fell");
    end
  endtask

  task automatic take_trap();
    int n;
    n = 0;
    while (!int_trap_req && n < 50) begin
      next_cycle();
      n++;
    end
    if (!int_trap_req) begin
      report_timeout("no trap request arrived");
    end else begin
      i_checker.compare(name, exp_v, 64'(int_trap_cause));
      if (arg_a[7:0] != 8'hff) begin
        {int_nmi, int_external, int_software} = arg_a[2:0]; // New sources
      end
      if (exp_v == 64'(CAUSE_NMI)) begin
        int_nmi = 1'b0; // NMI line withdrawn once its trap is taken
      end
      if (arg_b[7:0] != 8'hff) begin
        {mstatus_mie, mie_meie, mie_mtie, mie_msie} = arg_b[3:0];
      end
      repeat (3) next_cycle(); // Slow ack, cause must stay frozen
      int_trap_ack = 1'b1;
      n = 0;
      while (int_trap_req && n < 50) begin
        next_cycle();
        n++;
      end
      if (int_trap_req) begin
        report_timeout("trap request stayed high after ack");
      end
      int_trap_ack = 1'b0;
      next_cycle();
    end
  endtask

  // --------------------------------------------------
  // Record interpreter

  task automatic run_record();
    xword_t rd;
    logic   err;
    ctr_t   c0;
    int     free_edges;
    if (op == "wr") begin
      mmio_access(1'b1, arg_a[31:0], arg_b[31:0], rd, err);
      i_checker.compare(name, exp_v, 64'(err));
    end else if (op == "rd") begin
      mmio_access(1'b0, arg_a[31:0], '0, rd, err);
      i_checker.compare(name, exp_v, 64'(rd));
      i_checker.compare(name, arg_b, 64'(err)); // Expected error flag
    end else if (op == "snap") begin
      mmio_access(1'b0, arg_a[31:0], '0, rd, err);
      last_rd = rd;
      i_checker.compare(name, arg_b, 64'(err));
      i_checker.compare(name, time_edges, ctr_time); // mtime counts every edge
    end else if (op == "cmprel") begin
      mmio_access(1'b1, MMIO_BASE_ADDR | MMIO_MTIMECMP_HI, '0, rd, err);
      mmio_access(1'b1, MMIO_BASE_ADDR | MMIO_MTIMECMP_LO, last_rd + arg_a[31:0], rd, err);
      i_checker.compare(name, exp_v, 64'(err));
    end else if (op == "cyc") begin
      c0         = ctr_cycle;
      free_edges = 0;
      inhibit_cy = 1'b1;
      repeat (int'(arg_a)) next_cycle();
      inhibit_cy = 1'b0;
      repeat (int'(arg_b)) begin
        next_cycle();
        free_edges++; // Edges that may count
      end
      i_checker.compare(name, 64'(free_edges), ctr_cycle - c0);
      i_checker.compare(name, exp_v, ctr_cycle - c0);
    end else if (op == "ret") begin
      c0         = ctr_instret;
      instr_ret  = 1'b1;
      inhibit_ir = arg_b[0];
      repeat (int'(arg_a)) next_cycle();
      instr_ret  = 1'b0;
      inhibit_ir = 1'b0;
      i_checker.compare(name, exp_v, ctr_instret - c0);
    end else if (op == "en") begin
      {mstatus_mie, mie_meie, mie_mtie, mie_msie} = arg_a[3:0];
      next_cycle();
    end else if (op == "src") begin
      {int_nmi, int_external, int_software} = arg_a[2:0];
      int_extern_cause = arg_b[3:0];
      next_cycle();
    end else if (op == "idle") begin
      repeat (int'(arg_a)) next_cycle();
      i_checker.compare(name, exp_v,
                        64'({int_trap_req, mip_meip, mip_mtip, mip_msip}));
    end else if (op == "poll") begin
      free_edges = 0;
      while (!int_mtime && free_edges < 50) begin
        next_cycle();
        free_edges++;
      end
      if (!int_mtime) begin
        report_timeout("int_mtime never rose");
      end else begin
        i_checker.compare(name, exp_v, 64'(mip_mtip));
      end
    end else if (op == "trap") begin
      take_trap();
    end else begin
      $display("unknown operation %0s in record %0s", op, name);
      other_failures++;
    end
  endtask

  // --------------------------------------------------
  // Main sequence

  initial begin
    other_failures = 0;
    stop           = 1'b0;
    last_rd        = '0;
    reset          = 1'b1;
    {instr_ret, inhibit_cy, inhibit_tm, inhibit_ir} = '0;
    {mstatus_mie, mie_meie, mie_mtie, mie_msie}     = '0;
    {int_nmi, int_external, int_software, int_trap_ack} = '0;
    int_extern_cause = '0;
    mmio_req   = 1'b0;
    mmio_wen   = 1'b0;
    mmio_addr  = '0;
    mmio_wdata = '0;
    repeat (4) @(posedge g_clk); // Reset for 4 cycles
    #1;
    reset = 1'b0;
    next_cycle();

    fd = $fopen("frv_uncore_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file frv_uncore_stim.txt");
      other_failures++;
    end else begin
      while (!stop && !$feof(fd)) begin
        line = '0;
        r    = $fgets(line, fd);
        if (r > 0) begin
          r = $sscanf(line, "%s %s %h %h %h", name, op, arg_a, arg_b, exp_v);
          if (r == 5 && name != "#") begin
            run_record();
          end
        end
      end
      $fclose(fd);
    end

    $display("errors: %0d mismatches, %0d other failures", mismatches, other_failures);
    if (mismatches == 0 && other_failures == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- frv_uncore_stim.txt
# name op arg_a arg_b expected, all numbers hex
# en={mie,meie,mtie,msie} src={nmi,ext,sw} trap: arg_a/arg_b new src/en after req
mm_wr_cmplo wr 1008 12345678 0
mm_wr_cmphi wr 100c 0000abcd 0
mm_rd_cmplo rd 1008 0 12345678
mm_rd_cmphi rd 100c 0 0000abcd
mm_rd_out rd 2000 1 0
mm_rd_off rd 1002 1 0
mm_wr_bad wr 1010 5 1
cyc_inhibit cyc 6 a a
ret_count ret 7 0 7
ret_inhibit ret 5 1 0
tm_snap snap 1000 0 0
tm_cmp_rel cmprel 18 0 0
tm_poll poll 0 0 1
tm_no_req idle 4 0 2
tm_en en a 0 0
tm_trap trap ff 0 7
tm_clr_lo wr 1008 ffffffff 0
tm_clr_hi wr 100c ffffffff 0
tm_cleared idle 4 0 0
ex_en en c 0 0
ex_src src 2 5 0
ex_trap trap 0 ff 15
sw_en en 9 0 0
sw_src src 1 0 0
sw_trap trap 0 ff 3
dis_en en 8 0 0
dis_src src 1 0 0
dis_no_req idle 5 0 1
dis_clr src 0 0 0
pr_en en d 0 0
pr_src src 7 9 0
pr_nmi trap 6 ff 3f
pr_ext trap 1 ff 19
pr_sw trap 0 ff 3

//--- flist.f
frv_pkg.sv
frv_counters.sv
frv_interrupt.sv
frv_uncore.sv
frv_uncore_checker.sv
tb_frv_uncore.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the uncore testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_frv_uncore -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "Everything OK" \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
